// File: filelist.f
ioBusPkg.sv
sendFifoPkg.sv
fifoWrIf.sv
ioAddrDecode.sv
sendPortRegs.sv
writeAligner.sv
byteLaneMem.sv
sendFifo.sv
perifSendPort.sv
perifSendPort_properties.sv
perifSendPortTb.sv

// File: Makefile
TOP = perifSendPortTb

all: run

obj_dir/V$(TOP): filelist.f *.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

// File: perifSendPortTb.sv
`timescale 1ns/100ps

module perifSendPortTb import ioBusPkg::*, sendFifoPkg::*; ();

  localparam ioAddrT base      = 16'h0040;
  localparam int     depth     = 32;
  localparam int     waitLimit = 40;

  typedef enum logic [2:0] {opWrite, opStatus, opClear, opPop, opBad} opT;

  // cnt repeats a write or gives a pop length
  // ackErr holds the expected addrAck and addrErr bits of a bus access
  typedef struct {
    opT         kind;
    ioAddrT     addr;
    ioSizeT     wrSize;
    ioSizeT     rdSize;
    int         cnt;
    logic [1:0] ackErr;
  } rowT;

  logic   clkH;
  logic   arstN;
  ioAddrT ioAddr;
  ioSizeT ioWrSize;
  ioSizeT ioRdSize;
  ioDataT ioMosi;
  ioDataT ioMiso;
  logic   addrAck;
  logic   addrErr;
  byteT   txData;
  logic   txRdEn;
  logic   txHasData;

  rowT    rows[$];
  byteT   model[$];
  int     errCnt;
  int     checkCnt;
  logic   gotAck;
  logic   gotErr;
  ioDataT gotMiso;

  perifSendPort #(.addrBase(base), .addrUsed(32'h10101250), .fifoAddrLen(5)) i_dut (.*);

  initial clkH = 1'b0;
  always #50 clkH = ~clkH;

  task automatic addRow(opT kind, ioAddrT addr, ioSizeT wr, ioSizeT rd, int cnt,
                        logic [1:0] ackErr);
    rows.push_back('{kind, addr, wr, rd, cnt, ackErr});
  endtask

  task automatic compareValue(string name, logic [63:0] got, logic [63:0] exp);
    checkCnt++;
    assert (got === exp) else begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errCnt++;
    end
  endtask

  // one access cycle with outputs captured mid-cycle
  task automatic busCycle(ioAddrT addr, ioSizeT wr, ioSizeT rd, ioDataT data);
    @(posedge clkH);
    ioAddr   <= addr;
    ioWrSize <= wr;
    ioRdSize <= rd;
    ioMosi   <= data;
    @(negedge clkH);
    gotAck  = addrAck;
    gotErr  = addrErr;
    gotMiso = ioMiso;
    @(posedge clkH);
    ioWrSize <= '0;
    ioRdSize <= '0;
  endtask

  task automatic popBytes(int n);
    int   i;
    logic seen;
    i    = 0;
    seen = 1'b0;
    if (n > model.size()) begin
      $display("ERROR: pop of %0d bytes asked with only %0d queued", n, model.size());
      errCnt++;
      return;
    end
    while (!seen && i < waitLimit) begin
      @(negedge clkH);
      seen = txHasData;
      i++;
    end
    if (!seen) begin
      $display("ERROR: timed out waiting for txHasData");
      errCnt++;
      return;
    end
    for (int k = 0; k < n; k++) begin
      @(posedge clkH);
      txRdEn <= 1'b1;
      @(negedge clkH);
      compareValue("txData", 64'(txData), 64'(model.pop_front()));
    end
    @(posedge clkH);
    txRdEn <= 1'b0;
  endtask

  task automatic buildTable();
    addRow(opStatus, 16'h0041, '0, sizeW, 1, 2'b10);
    // byte writes then drain
    addRow(opWrite, 16'h0040, sizeB, '0, 5, 2'b10);
    addRow(opStatus, 16'h0041, '0, sizeW, 1, 2'b10);
    addRow(opPop, 16'h0040, '0, '0, 5, 2'b00);
    // mixed sizes from an odd fill level across lane and row wraps
    addRow(opWrite, 16'h0040, sizeB, '0, 1, 2'b10);
    addRow(opWrite, 16'h0040, sizeW, '0, 1, 2'b10);
    addRow(opWrite, 16'h0040, sizeD, '0, 1, 2'b10);
    addRow(opWrite, 16'h0040, sizeQ, '0, 2, 2'b10);
    addRow(opStatus, 16'h0041, '0, sizeW, 1, 2'b10);
    addRow(opPop, 16'h0040, '0, '0, 10, 2'b00);
    addRow(opStatus, 16'h0041, '0, sizeW, 1, 2'b10);
    addRow(opWrite, 16'h0040, sizeD, '0, 1, 2'b10);
    addRow(opWrite, 16'h0040, sizeQ, '0, 1, 2'b10);
    addRow(opPop, 16'h0040, '0, '0, 25, 2'b00);
    // decode errors must leave the queue alone
    addRow(opWrite, 16'h0040, sizeW, '0, 2, 2'b10);
    addRow(opBad, 16'h0043, sizeQ, '0, 1, 2'b01);
    addRow(opBad, 16'h0080, sizeB, '0, 1, 2'b00);
    addRow(opBad, 16'h0040, '0, sizeQ, 1, 2'b01);
    addRow(opStatus, 16'h0041, '0, sizeW, 1, 2'b10);
    addRow(opPop, 16'h0040, '0, '0, 2, 2'b00);
    addRow(opClear, 16'h0042, sizeB, '0, 1, 2'b10);
    addRow(opStatus, 16'h0041, '0, sizeW, 1, 2'b10);
    // overflow drops the 8-byte and 1-byte writes
    addRow(opWrite, 16'h0040, sizeQ, '0, 3, 2'b10);
    addRow(opWrite, 16'h0040, sizeD, '0, 1, 2'b10);
    addRow(opWrite, 16'h0040, sizeQ, '0, 1, 2'b10);
    addRow(opStatus, 16'h0041, '0, sizeW, 1, 2'b10);
    addRow(opWrite, 16'h0040, sizeD, '0, 1, 2'b10);
    addRow(opStatus, 16'h0041, '0, sizeW, 1, 2'b10);
    addRow(opWrite, 16'h0040, sizeB, '0, 1, 2'b10);
    addRow(opPop, 16'h0040, '0, '0, 32, 2'b00);
    addRow(opStatus, 16'h0041, '0, sizeW, 1, 2'b10);
  endtask

  initial begin
    ioDataT data;
    int     startErr;
    void'($urandom(77867));
    arstN    = 1'b0;
    ioAddr   = '0;
    ioWrSize = '0;
    ioRdSize = '0;
    ioMosi   = '0;
    txRdEn   = 1'b0;
    errCnt   = 0;
    checkCnt = 0;
    buildTable();
    repeat (4) @(posedge clkH);
    arstN <= 1'b1;
    foreach (rows[r]) begin
      startErr = errCnt;
      case (rows[r].kind)
        opWrite: begin
          for (int k = 0; k < rows[r].cnt; k++) begin
            data = {$urandom, $urandom};
            busCycle(rows[r].addr, rows[r].wrSize, '0, data);
            compareValue("addrAck", 64'(gotAck), 64'(rows[r].ackErr[1]));
            compareValue("addrErr", 64'(gotErr), 64'(rows[r].ackErr[0]));
            // whole write is kept only if it fits
            if (int'(rows[r].wrSize) <= depth - model.size()) begin
              for (int i = 0; i < int'(rows[r].wrSize); i++) begin
                model.push_back(data[8*i +: 8]);
              end
            end
          end
        end
        opStatus: begin
          busCycle(rows[r].addr, '0, rows[r].rdSize, '0);
          compareValue("addrAck", 64'(gotAck), 64'(rows[r].ackErr[1]));
          compareValue("addrErr", 64'(gotErr), 64'(rows[r].ackErr[0]));
          compareValue("ioMiso", gotMiso, 64'(depth - model.size()));
        end
        opClear: begin
          busCycle(rows[r].addr, rows[r].wrSize, '0, '0);
          compareValue("addrAck", 64'(gotAck), 64'(rows[r].ackErr[1]));
          compareValue("addrErr", 64'(gotErr), 64'(rows[r].ackErr[0]));
          model.delete();
          @(negedge clkH);
          compareValue("txHasData", 64'(txHasData), 64'd0);
        end
        opPop: popBytes(rows[r].cnt);
        opBad: begin
          busCycle(rows[r].addr, rows[r].wrSize, rows[r].rdSize, {$urandom, $urandom});
          compareValue("addrAck", 64'(gotAck), 64'(rows[r].ackErr[1]));
          compareValue("addrErr", 64'(gotErr), 64'(rows[r].ackErr[0]));
        end
      endcase
      $display("row %0d %s: %s", r, rows[r].kind.name(), errCnt == startErr ? "ok" : "failed");
    end
    $display("rows %0d, checks %0d, errors %0d", rows.size(), checkCnt, errCnt);
    if (errCnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: perifSendPort_properties.sv
`timescale 1ns/100ps

module perifSendPortProps import sendFifoPkg::*; #(
  parameter int fifoAddrLen = 5
) (
  input logic clkH,
  input logic arstN,
  input logic addrAck,
  input logic addrErr,
  input logic txRdEn,
  input logic txHasData,
  input logic clr,
  input fillT freeSize
);

  localparam fillT depth = fillT'(1 << fifoAddrLen);

  ackErrExclusive: assert property (@(posedge clkH) disable iff (!arstN) !(addrAck && addrErr))
    else $error("addrAck and addrErr high in the same cycle");

  // full free space means nothing to pop
  noPopWhenEmpty: assert property (@(posedge clkH) disable iff (!arstN)
    txRdEn |-> freeSize != depth)
    else $error("txRdEn while the FIFO is empty");

  lowAfterClear: assert property (@(posedge clkH) disable iff (!arstN) clr |=> !txHasData)
    else $error("txHasData high in the cycle after a clear");

endmodule

bind perifSendPort perifSendPortProps #(.fifoAddrLen(fifoAddrLen)) uProps (
  .clkH      (clkH),
  .arstN     (arstN),
  .addrAck   (addrAck),
  .addrErr   (addrErr),
  .txRdEn    (txRdEn),
  .txHasData (txHasData),
  .clr       (fifoWr.clr),
  .freeSize  (fifoWr.freeSize)
);

// File: perifSendPort.sv
`timescale 1ns/100ps

module perifSendPort import ioBusPkg::*, sendFifoPkg::*; #(
  parameter ioAddrT      addrBase    = 16'h0040,
  parameter logic [31:0] addrUsed    = 32'h10101250,
  parameter int          fifoAddrLen = 5
) (
  input  logic   clkH,
  input  logic   arstN,
  input  ioAddrT ioAddr,
  input  ioSizeT ioWrSize,
  input  ioSizeT ioRdSize,
  input  ioDataT ioMosi,
  output ioDataT ioMiso,
  output logic   addrAck,
  output logic   addrErr,
  output byteT   txData,
  input  logic   txRdEn,
  output logic   txHasData
);

  ioAccessU access;
  fifoWrIf  fifoWr ();

  ioAddrDecode #(.addrBase(addrBase), .addrUsed(addrUsed)) uDecode (
    .ioAddr   (ioAddr),
    .ioWrSize (ioWrSize),
    .ioRdSize (ioRdSize),
    .access   (access),
    .addrAck  (addrAck),
    .addrErr  (addrErr)
  );

  sendPortRegs uRegs (
    .access (access),
    .ioMosi (ioMosi),
    .ioMiso (ioMiso),
    .fifoWr (fifoWr.regs)
  );

  sendFifo #(.fifoAddrLen(fifoAddrLen)) uFifo (
    .clkH      (clkH),
    .arstN     (arstN),
    .fifoWr    (fifoWr.fifo),
    .txData    (txData),
    .txRdEn    (txRdEn),
    .txHasData (txHasData)
  );

endmodule

// File: sendFifo.sv
`timescale 1ns/100ps

module sendFifo import ioBusPkg::*, sendFifoPkg::*; #(
  parameter int fifoAddrLen = 5
) (
  input  logic  clkH,
  input  logic  arstN,
  fifoWrIf.fifo fifoWr,
  output byteT  txData,
  input  logic  txRdEn,
  output logic  txHasData
);

  localparam int rowW  = fifoAddrLen - laneShW;
  localparam int depth = 1 << fifoAddrLen;

  // one extra bit tells full from empty
  typedef logic [fifoAddrLen:0] idxT;

  idxT                          wrIdx;
  idxT                          rdIdx;
  idxT                          fillCnt;
  logic                         doPush;
  byteT [laneCnt-1:0]           alignData;
  logic [laneCnt-1:0]           alignMask;
  logic [laneCnt-1:0][rowW-1:0] alignAddr;
  logic [laneCnt-1:0]           laneWe;
  byteT [laneCnt-1:0]           memData;
  ioDataT                       ror4, ror2, ror1;

  assign doPush = fifoWr.push & ~fifoWr.clr;

  writeAligner #(.fifoAddrLen(fifoAddrLen)) uAligner (
    .wrIdx      (wrIdx[fifoAddrLen-1:0]),
    .wrData     (fifoWr.wrData),
    .wrSize     (fifoWr.wrSize),
    .laneData   (alignData),
    .laneWrMask (alignMask),
    .laneAddr   (alignAddr)
  );

  assign laneWe = alignMask & {laneCnt{doPush}};

  for (genvar lane = 0; lane < laneCnt; lane++) begin : gLane
    byteLaneMem #(.addrLen(rowW)) uMem (
      .clkH   (clkH),
      .arstN  (arstN),
      .wrAddr (alignAddr[lane]),
      .wrData (alignData[lane]),
      .wrEn   (laneWe[lane]),
      .rdAddr (rdIdx[fifoAddrLen-1:laneShW]),
      .rdData (memData[lane])
    );
  end

  // oldest byte rotated down into lane 0
  assign ror4 = rdIdx[2] ? {memData[3:0], memData[7:4]} : memData;
  assign ror2 = rdIdx[1] ? {ror4[15:0], ror4[63:16]} : ror4;
  assign ror1 = rdIdx[0] ? {ror2[7:0], ror2[63:8]} : ror2;
  assign txData = ror1[7:0];

  always_ff @(posedge clkH or negedge arstN) begin
    if (!arstN) begin
      wrIdx     <= '0;
      rdIdx     <= '0;
      txHasData <= 1'b0;
    end else begin
      if (fifoWr.clr) begin
        wrIdx <= '0;
        rdIdx <= '0;
      end else begin
        if (fifoWr.push) begin
          wrIdx <= wrIdx + idxT'(fifoWr.wrSize);
        end
        rdIdx <= rdIdx + idxT'(txRdEn);
      end
      // held low while a pop or clear is in flight
      txHasData <= (|fillCnt) & ~txRdEn & ~fifoWr.clr;
    end
  end

  assign fillCnt         = wrIdx - rdIdx;
  assign fifoWr.freeSize = fillT'(depth) - fillT'(fillCnt);

endmodule

// File: byteLaneMem.sv
`timescale 1ns/100ps

module byteLaneMem import sendFifoPkg::*; #(
  parameter int addrLen = 2
) (
  input  logic               clkH,
  input  logic               arstN,
  input  logic [addrLen-1:0] wrAddr,
  input  byteT               wrData,
  input  logic               wrEn,
  input  logic [addrLen-1:0] rdAddr,
  output byteT               rdData
);

  localparam int depth = 1 << addrLen;

  byteT mem [depth];

  always_ff @(posedge clkH or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < depth; i++) begin
        mem[i] <= '0;
      end
    end else if (wrEn) begin
      mem[wrAddr] <= wrData;
    end
  end

  // read port is asynchronous
  assign rdData = mem[rdAddr];

endmodule

// File: writeAligner.sv
`timescale 1ns/100ps

module writeAligner import ioBusPkg::*, sendFifoPkg::*; #(
  parameter int fifoAddrLen = 5
) (
  input  logic [fifoAddrLen-1:0]                    wrIdx,
  input  ioDataT                                    wrData,
  input  ioSizeT                                    wrSize,
  output byteT [laneCnt-1:0]                        laneData,
  output logic [laneCnt-1:0]                        laneWrMask,
  output logic [laneCnt-1:0][fifoAddrLen-laneShW-1:0] laneAddr
);

  typedef logic [fifoAddrLen-laneShW-1:0] rowT;

  logic [laneShW-1:0]   shift;
  logic [laneCnt-1:0]   sizeMask;
  ioDataT               dat4, dat2, dat1;
  logic [laneCnt-1:0]   msk4, msk2, msk1;
  logic [2*laneCnt-1:0] spread;
  rowT                  rowCur;
  rowT                  rowNext;

  assign shift = wrIdx[laneShW-1:0];

  // 1/2/4/8 bytes to a low-aligned byte mask
  assign sizeMask = {{4{wrSize[3]}}, {2{|wrSize[3:2]}}, |wrSize[3:1], |wrSize};

  // rotate left in byte steps of 4, 2, 1
  assign dat4 = shift[2] ? {wrData[31:0], wrData[63:32]} : wrData;
  assign dat2 = shift[1] ? {dat4[47:0], dat4[63:48]} : dat4;
  assign dat1 = shift[0] ? {dat2[55:0], dat2[63:56]} : dat2;

  assign msk4 = shift[2] ? {sizeMask[3:0], sizeMask[7:4]} : sizeMask;
  assign msk2 = shift[1] ? {msk4[5:0], msk4[7:6]} : msk4;
  assign msk1 = shift[0] ? {msk2[6:0], msk2[7]} : msk2;

  assign laneData   = dat1;
  assign laneWrMask = msk1;

  // upper half marks lanes that wrapped past lane 7
  assign spread  = {{laneCnt{1'b0}}, sizeMask} << shift;
  assign rowCur  = wrIdx[fifoAddrLen-1:laneShW];
  assign rowNext = rowCur + rowT'(1);

  always_comb begin
    for (int k = 0; k < laneCnt; k++) begin
      laneAddr[k] = spread[laneCnt+k] ? rowNext : rowCur;
    end
  end

endmodule

// File: sendPortRegs.sv
`timescale 1ns/100ps

module sendPortRegs import ioBusPkg::*, sendFifoPkg::*; (
  input  ioAccessU access,
  input  ioDataT   ioMosi,
  output ioDataT   ioMiso,
  fifoWrIf.regs    fifoWr
);

  ioSizeT wrSize;
  fillT   byteCnt;
  logic   fits;

  // data register accepts any size, back to a one-hot code
  always_comb begin
    if (access.en.wrQ[laneData]) begin
      wrSize = sizeQ;
    end else if (access.en.wrD[laneData]) begin
      wrSize = sizeD;
    end else if (access.en.wrW[laneData]) begin
      wrSize = sizeW;
    end else if (access.en.wrB[laneData]) begin
      wrSize = sizeB;
    end else begin
      wrSize = '0;
    end
  end

  assign byteCnt = fillT'(wrSize);

  // too large a write is dropped whole
  assign fits = (byteCnt <= fifoWr.freeSize);

  assign fifoWr.push   = (|wrSize) & fits;
  assign fifoWr.wrSize = wrSize;
  assign fifoWr.wrData = ioMosi;
  assign fifoWr.clr    = access.en.wrB[laneClear];

  // status word, free space in bytes
  assign ioMiso = access.en.rdW[laneStatus] ? ioDataT'(fifoWr.freeSize) : '0;

endmodule

// File: ioAddrDecode.sv
`timescale 1ns/100ps

module ioAddrDecode import ioBusPkg::*; #(
  parameter ioAddrT      addrBase = 16'h0040,
  parameter logic [31:0] addrUsed = 32'h10101250
) (
  input  ioAddrT   ioAddr,
  input  ioSizeT   ioWrSize,
  input  ioSizeT   ioRdSize,
  output ioAccessU access,
  output logic     addrAck,
  output logic     addrErr
);

  logic       baseHit;
  ioSizeT     wrSize;
  ioSizeT     rdSize;
  logic [3:0] laneDec;

  // window of four lanes at the base address
  assign baseHit = (ioAddr[15:2] == addrBase[15:2]);
  assign wrSize  = baseHit ? ioWrSize : '0;
  assign rdSize  = baseHit ? ioRdSize : '0;
  assign laneDec = 4'b0001 << ioAddr[1:0];

  always_comb begin
    access.en.wrQ = {4{wrSize[3]}} & laneDec;
    access.en.rdQ = {4{rdSize[3]}} & laneDec;
    access.en.wrD = {4{wrSize[2]}} & laneDec;
    access.en.rdD = {4{rdSize[2]}} & laneDec;
    access.en.wrW = {4{wrSize[1]}} & laneDec;
    access.en.rdW = {4{rdSize[1]}} & laneDec;
    access.en.wrB = {4{wrSize[0]}} & laneDec;
    access.en.rdB = {4{rdSize[0]}} & laneDec;
  end

  // only implemented size/lane pairs are acknowledged
  assign addrAck = |(access.flat & addrUsed);
  assign addrErr = baseHit & ~addrAck;

endmodule

// File: fifoWrIf.sv
`timescale 1ns/100ps

interface fifoWrIf import ioBusPkg::*, sendFifoPkg::*; ();

  logic   push;
  ioDataT wrData;
  ioSizeT wrSize;
  logic   clr;
  fillT   freeSize;

  modport regs (output push, wrData, wrSize, clr, input freeSize);

  modport fifo (input push, wrData, wrSize, clr, output freeSize);

endinterface

// File: sendFifoPkg.sv
package sendFifoPkg;

  typedef logic [7:0] byteT;

  // byte lanes across one 64-bit row
  localparam int laneCnt = 8;

  // bits needed to select a lane, also the rotate amount width
  localparam int laneShW = 3;

  // free and fill counts as seen on the bus
  typedef logic [15:0] fillT;

endpackage

// File: ioBusPkg.sv
package ioBusPkg;

  typedef logic [15:0] ioAddrT;
  typedef logic [3:0]  ioSizeT;
  typedef logic [63:0] ioDataT;

  // one-hot size codes, value equals the byte count
  localparam ioSizeT sizeQ = 4'b1000;
  localparam ioSizeT sizeD = 4'b0100;
  localparam ioSizeT sizeW = 4'b0010;
  localparam ioSizeT sizeB = 4'b0001;

  // register offsets within the 4-lane window
  localparam logic [1:0] laneData   = 2'd0;
  localparam logic [1:0] laneStatus = 2'd1;
  localparam logic [1:0] laneClear  = 2'd2;

  // flat view for the ack mask, per-size lane vectors for the register block
  typedef union packed {
    logic [31:0] flat;
    struct packed {
      logic [3:0] wrQ, rdQ, wrD, rdD, wrW, rdW, wrB, rdB;
    } en;
  } ioAccessU;

endpackage
